//--- verilog/mem_ctrl_pkg.sv
package mem_ctrl_pkg;

    // number of cache ports, 0 is instruction fetch, 1 is data
    localparam int NUM_PORTS = 2;

    // cache geometry
    localparam int LINE_BYTES  = 16;
    localparam int LINE_BITS   = LINE_BYTES * 8;  // 128
    localparam int LINE_COUNT  = 16;              // lines per cache
    localparam int INDEX_BITS  = 4;
    localparam int OFFSET_BITS = 4;
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;  // 24

    // byte-size codes on the core side
    localparam logic [1:0] SIZE_WORD = 2'd0;  // 32 bit
    localparam logic [1:0] SIZE_BYTE = 2'd1;  // 8 bit
    localparam logic [1:0] SIZE_HALF = 2'd2;  // 16 bit

endpackage

//--- verilog/line_cache.sv
`timescale 1ns/10ps

module line_cache (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [mem_ctrl_pkg::INDEX_BITS-1:0]  index,
    input  logic [mem_ctrl_pkg::TAG_BITS-1:0]    tag_in,
    input  logic [mem_ctrl_pkg::OFFSET_BITS-1:0] offset,
    input  logic [1:0]                           byte_size,
    input  logic [31:0]                          wdata,
    input  logic                                 write_word,
    input  logic                                 refill_en,
    input  logic [mem_ctrl_pkg::LINE_BITS-1:0]   refill_data,
    output logic                                 hit,
    output logic                                 victim_dirty,
    output logic [mem_ctrl_pkg::TAG_BITS-1:0]    victim_tag,
    output logic [mem_ctrl_pkg::LINE_BITS-1:0]   victim_data,
    output logic [31:0]                          rdata
);

    logic [mem_ctrl_pkg::TAG_BITS-1:0]  tag_mem  [mem_ctrl_pkg::LINE_COUNT];
    logic [mem_ctrl_pkg::LINE_BITS-1:0] line_mem [mem_ctrl_pkg::LINE_COUNT];
    logic [mem_ctrl_pkg::LINE_COUNT-1:0] valid;
    logic [mem_ctrl_pkg::LINE_COUNT-1:0] dirty;

    logic [mem_ctrl_pkg::LINE_BITS-1:0] cur_line;
    logic [1:0]                         word_sel;
    logic [31:0]                        cur_word;
    logic [3:0]                         byte_en;    // lanes touched within the word
    logic [31:0]                        wdata_rep;  // write data replicated over the lanes
    logic [mem_ctrl_pkg::LINE_BITS-1:0] merged_line;

    assign cur_line = line_mem[index];
    assign word_sel = offset[mem_ctrl_pkg::OFFSET_BITS-1:2];
    assign cur_word = cur_line[{word_sel, 5'b0} +: 32];

    // lookup
    assign hit          = valid[index] && (tag_mem[index] == tag_in);
    assign victim_dirty = valid[index] && dirty[index];
    assign victim_tag   = tag_mem[index];
    assign victim_data  = cur_line;

    // sized read, zero-extended
    always_comb begin
        case (byte_size)
            mem_ctrl_pkg::SIZE_BYTE: rdata = {24'b0, cur_word[{offset[1:0], 3'b0} +: 8]};
            mem_ctrl_pkg::SIZE_HALF: rdata = {16'b0, cur_word[{offset[1], 4'b0} +: 16]};
            default:                 rdata = cur_word;
        endcase
    end

    // lane enables for the sized write
    always_comb begin
        case (byte_size)
            mem_ctrl_pkg::SIZE_BYTE: begin
                byte_en   = 4'b0001 << offset[1:0];
                wdata_rep = {4{wdata[7:0]}};
            end
            mem_ctrl_pkg::SIZE_HALF: begin
                byte_en   = 4'b0011 << {offset[1], 1'b0};
                wdata_rep = {2{wdata[15:0]}};
            end
            default: begin
                byte_en   = 4'b1111;
                wdata_rep = wdata;
            end
        endcase
    end

    // merge the addressed bytes into the current line
    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < mem_ctrl_pkg::LINE_BYTES; b++) begin
            if ((b / 4) == int'(word_sel) && byte_en[b % 4]) begin
                merged_line[b*8 +: 8] = wdata_rep[(b % 4)*8 +: 8];
            end
        end
    end

    // line and tag storage
    always_ff @(posedge clk) begin
        if (refill_en) begin
            line_mem[index] <= refill_data;
            tag_mem[index]  <= tag_in;
        end else if (write_word) begin
            line_mem[index] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (refill_en) begin
            valid[index] <= 1'b1;
            dirty[index] <= 1'b0;  // fresh line from memory is clean
        end else if (write_word) begin
            dirty[index] <= 1'b1;
        end
    end

    // refill happens in the port's refill state and writes only on completion
    a_no_refill_and_write: assert property (
        @(posedge clk) disable iff (rst) !(refill_en && write_word)
    );

endmodule

//--- verilog/cache_port.sv
`timescale 1ns/10ps

module cache_port (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [31:0]                        addr,
    input  logic                               read_en,
    input  logic                               write_en,
    input  logic [1:0]                         byte_size,
    input  logic [31:0]                        wdata,
    output logic [31:0]                        rdata,
    output logic                               ready,
    output logic                               line_read_req,
    output logic                               line_write_req,
    output logic [31:0]                        line_addr,
    output logic [mem_ctrl_pkg::LINE_BITS-1:0] line_wdata,
    input  logic [mem_ctrl_pkg::LINE_BITS-1:0] line_rdata,
    input  logic                               line_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITEBACK,
        ST_REFILL,
        ST_COMPLETE
    } state_t;

    state_t state;
    state_t state_next;

    logic                                req;
    logic                                hit;
    logic                                victim_dirty;
    logic [mem_ctrl_pkg::TAG_BITS-1:0]   victim_tag;
    logic [mem_ctrl_pkg::INDEX_BITS-1:0] index;
    logic                                refill_en;
    logic                                write_word;

    assign req   = read_en | write_en;
    assign index = addr[mem_ctrl_pkg::INDEX_BITS+mem_ctrl_pkg::OFFSET_BITS-1:
                        mem_ctrl_pkg::OFFSET_BITS];

    line_cache i_line_cache (
        .clk          (clk),
        .rst          (rst),
        .index        (index),
        .tag_in       (addr[31:mem_ctrl_pkg::INDEX_BITS+mem_ctrl_pkg::OFFSET_BITS]),
        .offset       (addr[mem_ctrl_pkg::OFFSET_BITS-1:0]),
        .byte_size    (byte_size),
        .wdata        (wdata),
        .write_word   (write_word),
        .refill_en    (refill_en),
        .refill_data  (line_rdata),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_data  (line_wdata),
        .rdata        (rdata)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (req) begin
                    if (hit) begin
                        state_next = ST_COMPLETE;
                    end else if (victim_dirty) begin
                        state_next = ST_WRITEBACK;  // evict first
                    end else begin
                        state_next = ST_REFILL;
                    end
                end
            end
            ST_WRITEBACK: if (line_ack) state_next = ST_REFILL;
            ST_REFILL:    if (line_ack) state_next = ST_COMPLETE;
            default:      state_next = ST_IDLE;  // complete lasts one cycle
        endcase
    end

    // line is resident in complete, so the access is done there
    assign ready      = (state == ST_COMPLETE);
    assign write_word = (state == ST_COMPLETE) && write_en;
    assign refill_en  = (state == ST_REFILL) && line_ack;  // line_rdata valid with ack

    assign line_write_req = (state == ST_WRITEBACK);
    assign line_read_req  = (state == ST_REFILL);

    // victim address in write-back, missed line otherwise
    assign line_addr = (state == ST_WRITEBACK) ?
                       {victim_tag, index, {mem_ctrl_pkg::OFFSET_BITS{1'b0}}} :
                       {addr[31:mem_ctrl_pkg::OFFSET_BITS], {mem_ctrl_pkg::OFFSET_BITS{1'b0}}};

    a_one_access: assert property (
        @(posedge clk) disable iff (rst) !(read_en && write_en)
    );

    a_ready_pulse: assert property (
        @(posedge clk) disable iff (rst) ready && req |=> !ready
    );

endmodule

//--- verilog/offchip_arbiter.sv
`timescale 1ns/10ps

module offchip_arbiter (
    input  logic                                                         clk,
    input  logic                                                         rst,
    input  logic [mem_ctrl_pkg::NUM_PORTS-1:0]                           line_read_req,
    input  logic [mem_ctrl_pkg::NUM_PORTS-1:0]                           line_write_req,
    input  logic [mem_ctrl_pkg::NUM_PORTS-1:0][31:0]                     line_addr,
    input  logic [mem_ctrl_pkg::NUM_PORTS-1:0][mem_ctrl_pkg::LINE_BITS-1:0] line_wdata,
    output logic [mem_ctrl_pkg::LINE_BITS-1:0]                           line_rdata,
    output logic [mem_ctrl_pkg::NUM_PORTS-1:0]                           line_ack,
    output logic [31:0]                                                  mem_addr,
    output logic                                                         mem_read_en,
    output logic                                                         mem_write_en,
    output logic [mem_ctrl_pkg::LINE_BITS-1:0]                           mem_wdata,
    input  logic [mem_ctrl_pkg::LINE_BITS-1:0]                           mem_rdata,
    input  logic                                                         mem_ready
);

    typedef logic [$clog2(mem_ctrl_pkg::NUM_PORTS)-1:0] port_idx_t;

    logic                               busy;
    port_idx_t                          grant;
    port_idx_t                          next_grant;
    logic [mem_ctrl_pkg::NUM_PORTS-1:0] any_req;

    assign any_req = line_read_req | line_write_req;

    // lowest index wins, so instruction fetch beats data
    always_comb begin
        next_grant = '0;
        for (int p = mem_ctrl_pkg::NUM_PORTS - 1; p >= 0; p--) begin
            if (any_req[p]) next_grant = port_idx_t'(p);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            grant <= '0;
        end else if (!busy) begin
            if (|any_req) begin
                busy  <= 1'b1;
                grant <= next_grant;
            end
        end else if (mem_ready) begin
            busy <= 1'b0;  // one idle cycle before the next grant
        end
    end

    assign mem_read_en  = busy && line_read_req[grant];
    assign mem_write_en = busy && line_write_req[grant];
    assign mem_addr     = line_addr[grant];
    assign mem_wdata    = line_wdata[grant];

    assign line_rdata = mem_rdata;  // broadcast, only the acked port stores it

    always_comb begin
        line_ack = '0;
        line_ack[grant] = busy && mem_ready;
    end

    a_enables_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(mem_read_en && mem_write_en)
    );

endmodule

//--- verilog/mem_controller.sv
`timescale 1ns/10ps

module mem_controller (
    input  logic                                     clk,
    input  logic                                     rst,
    // core side, one slot per port
    input  logic [mem_ctrl_pkg::NUM_PORTS-1:0][31:0] addr,
    input  logic [mem_ctrl_pkg::NUM_PORTS-1:0]       read_en,
    input  logic [mem_ctrl_pkg::NUM_PORTS-1:0]       write_en,
    input  logic [mem_ctrl_pkg::NUM_PORTS-1:0][1:0]  byte_size,
    input  logic [mem_ctrl_pkg::NUM_PORTS-1:0][31:0] wdata,
    output logic [mem_ctrl_pkg::NUM_PORTS-1:0][31:0] rdata,
    output logic [mem_ctrl_pkg::NUM_PORTS-1:0]       ready,
    // off-chip line memory
    output logic [31:0]                              mem_addr,
    output logic                                     mem_read_en,
    output logic                                     mem_write_en,
    output logic [mem_ctrl_pkg::LINE_BITS-1:0]       mem_wdata,
    input  logic [mem_ctrl_pkg::LINE_BITS-1:0]       mem_rdata,
    input  logic                                     mem_ready
);

    logic [mem_ctrl_pkg::NUM_PORTS-1:0]                              line_read_req;
    logic [mem_ctrl_pkg::NUM_PORTS-1:0]                              line_write_req;
    logic [mem_ctrl_pkg::NUM_PORTS-1:0][31:0]                        line_addr;
    logic [mem_ctrl_pkg::NUM_PORTS-1:0][mem_ctrl_pkg::LINE_BITS-1:0] line_wdata;
    logic [mem_ctrl_pkg::LINE_BITS-1:0]                              line_rdata;
    logic [mem_ctrl_pkg::NUM_PORTS-1:0]                              line_ack;

    // port 0 fetches instructions, port 1 serves data
    for (genvar p = 0; p < mem_ctrl_pkg::NUM_PORTS; p++) begin : g_port
        cache_port i_cache_port (
            .clk            (clk),
            .rst            (rst),
            .addr           (addr[p]),
            .read_en        (read_en[p]),
            .write_en       (write_en[p]),
            .byte_size      (byte_size[p]),
            .wdata          (wdata[p]),
            .rdata          (rdata[p]),
            .ready          (ready[p]),
            .line_read_req  (line_read_req[p]),
            .line_write_req (line_write_req[p]),
            .line_addr      (line_addr[p]),
            .line_wdata     (line_wdata[p]),
            .line_rdata     (line_rdata),
            .line_ack       (line_ack[p])
        );
    end

    offchip_arbiter i_offchip_arbiter (
        .clk            (clk),
        .rst            (rst),
        .line_read_req  (line_read_req),
        .line_write_req (line_write_req),
        .line_addr      (line_addr),
        .line_wdata     (line_wdata),
        .line_rdata     (line_rdata),
        .line_ack       (line_ack),
        .mem_addr       (mem_addr),
        .mem_read_en    (mem_read_en),
        .mem_write_en   (mem_write_en),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready)
    );

endmodule

//--- dv/offchip_mem_model.sv
`timescale 1ns/10ps

module offchip_mem_model #(
    parameter int SEED = 1
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [31:0]                        mem_addr,
    input  logic                               mem_read_en,
    input  logic                               mem_write_en,
    input  logic [mem_ctrl_pkg::LINE_BITS-1:0] mem_wdata,
    output logic [mem_ctrl_pkg::LINE_BITS-1:0] mem_rdata,
    output logic                               mem_ready
);

    localparam int MEM_LINES = 512;  // 8 KB, covers both port regions

    logic [mem_ctrl_pkg::LINE_BITS-1:0] line_mem [MEM_LINES];
    logic [8:0]                         line_idx;
    logic [31:0]                        scramble;
    logic                               pending;
    int unsigned                        wait_cnt;
    int                                 fill_seed = SEED;
    int                                 lat_seed  = SEED;

    assign line_idx = mem_addr[12:4];

    initial scramble = $random(fill_seed);

    // word value mixes the full word address with the seeded constant
    function automatic logic [mem_ctrl_pkg::LINE_BITS-1:0] pattern_line(int l);
        logic [mem_ctrl_pkg::LINE_BITS-1:0] pat;
        for (int w = 0; w < 4; w++) begin
            pat[w*32 +: 32] = (32'(l * 16 + w * 4) * 32'h9e37_79b1) ^ scramble;
        end
        return pat;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            mem_ready <= 1'b0;
            pending   <= 1'b0;
            wait_cnt  <= 0;
            for (int l = 0; l < MEM_LINES; l++) begin
                line_mem[l] <= pattern_line(l);
            end
        end else if (mem_ready) begin
            mem_ready <= 1'b0;  // enables drop during this cycle
        end else if (pending) begin
            if (wait_cnt == 0) begin
                mem_ready <= 1'b1;
                pending   <= 1'b0;
                if (mem_write_en) begin
                    line_mem[line_idx] <= mem_wdata;
                end else begin
                    mem_rdata <= line_mem[line_idx];
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (mem_read_en || mem_write_en) begin
            pending  <= 1'b1;
            wait_cnt <= {$random(lat_seed)} % 6;  // extra wait cycles
        end
    end

endmodule

//--- dv/mem_controller_tb.sv
`timescale 1ns/10ps

module mem_controller_tb;

    localparam int NP         = mem_ctrl_pkg::NUM_PORTS;
    localparam int CLK_PERIOD = 4;
    localparam int RANDOM_OPS = 300;             // per port
    localparam int MAX_OPS    = 2 * RANDOM_OPS;  // random ops plus read-backs
    localparam int WORST_MISS = 40;              // write-back and refill behind the other port
    localparam int TIMEOUT_NS = NP * MAX_OPS * WORST_MISS * CLK_PERIOD * 2;

    logic                               clk;
    logic                               rst;
    logic [NP-1:0][31:0]                addr;
    logic [NP-1:0]                      read_en;
    logic [NP-1:0]                      write_en;
    logic [NP-1:0][1:0]                 byte_size;
    logic [NP-1:0][31:0]                wdata;
    logic [NP-1:0][31:0]                rdata;
    logic [NP-1:0]                      ready;
    logic [31:0]                        mem_addr;
    logic                               mem_read_en;
    logic                               mem_write_en;
    logic [mem_ctrl_pkg::LINE_BITS-1:0] mem_wdata;
    logic [mem_ctrl_pkg::LINE_BITS-1:0] mem_rdata;
    logic                               mem_ready;

    // pre-built operation list per port
    logic        op_write [NP][MAX_OPS];
    logic [31:0] op_addr  [NP][MAX_OPS];
    logic [1:0]  op_size  [NP][MAX_OPS];
    logic [31:0] op_wdata [NP][MAX_OPS];
    int          op_count [NP];
    logic [7:0]  ref_mem  [8192];  // byte image of both regions
    int          seed = 60085;

    mem_controller i_mem_controller (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .read_en      (read_en),
        .write_en     (write_en),
        .byte_size    (byte_size),
        .wdata        (wdata),
        .rdata        (rdata),
        .ready        (ready),
        .mem_addr     (mem_addr),
        .mem_read_en  (mem_read_en),
        .mem_write_en (mem_write_en),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready)
    );

    offchip_mem_model #(.SEED(60085)) mem_model (
        .clk          (clk),
        .rst          (rst),
        .mem_addr     (mem_addr),
        .mem_read_en  (mem_read_en),
        .mem_write_en (mem_write_en),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready)
    );

    task automatic check(string name, logic [127:0] actual, logic [127:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic add_op(int p, logic wr, logic [31:0] a, logic [1:0] sz, logic [31:0] d);
        op_write[p][op_count[p]] = wr;
        op_addr[p][op_count[p]]  = a;
        op_size[p][op_count[p]]  = sz;
        op_wdata[p][op_count[p]] = d;
        op_count[p]++;
    endtask

    task automatic build_ops();
        logic [31:0] a;
        logic [1:0]  sz;
        logic        wr;
        for (int p = 0; p < NP; p++) begin
            op_count[p] = 0;
            for (int i = 0; i < RANDOM_OPS; i++) begin
                if (i > 0 && {$random(seed)} % 4 == 0) begin
                    a  = op_addr[p][i-1];  // same address again
                    sz = op_size[p][i-1];
                    wr = 1'b0;
                end else begin
                    sz = 2'({$random(seed)} % 3);
                    a  = 32'(p * 4096) + {$random(seed)} % 4096;
                    if (sz == mem_ctrl_pkg::SIZE_WORD) begin
                        a[1:0] = 2'b00;
                    end else if (sz == mem_ctrl_pkg::SIZE_HALF) begin
                        a[0] = 1'b0;
                    end
                    wr = (p != 0) && ({$random(seed)} % 2 == 0);  // port 0 only fetches
                end
                add_op(p, wr, a, sz, $random(seed));
            end
        end
        // read back the whole word of every write after the random phase
        for (int i = 0; i < RANDOM_OPS; i++) begin
            if (op_write[1][i]) begin
                add_op(1, 1'b0, {op_addr[1][i][31:2], 2'b00}, mem_ctrl_pkg::SIZE_WORD, 32'h0);
            end
        end
    endtask

    function automatic logic [31:0] expected_read(logic [31:0] a, logic [1:0] sz);
        int b;
        b = int'(a[12:0]);
        case (sz)
            mem_ctrl_pkg::SIZE_BYTE: return {24'b0, ref_mem[b]};
            mem_ctrl_pkg::SIZE_HALF: return {16'b0, ref_mem[b+1], ref_mem[b]};
            default:                 return {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
        endcase
    endfunction

    task automatic apply_write(logic [31:0] a, logic [1:0] sz, logic [31:0] d);
        int b;
        b = int'(a[12:0]);
        ref_mem[b] = d[7:0];
        if (sz != mem_ctrl_pkg::SIZE_BYTE) begin
            ref_mem[b+1] = d[15:8];
        end
        if (sz == mem_ctrl_pkg::SIZE_WORD) begin
            ref_mem[b+2] = d[23:16];
            ref_mem[b+3] = d[31:24];
        end
    endtask

    function automatic logic [127:0] ref_line(logic [31:0] a);
        logic [127:0] l;
        for (int i = 0; i < 16; i++) begin
            l[i*8 +: 8] = ref_mem[int'({a[12:4], 4'b0}) + i];
        end
        return l;
    endfunction

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Error: run timed out after %0d ns with accesses still pending", TIMEOUT_NS);
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    // bus monitor checks line addresses and write-back data against the reference
    always @(negedge clk) begin
        if (!rst) begin
            check("mem_read_en && mem_write_en", 128'(mem_read_en && mem_write_en), 128'(0));
            if (mem_read_en || mem_write_en) begin
                check("mem_addr[31:13]", 128'(mem_addr[31:13]), 128'(0));
                check("mem_addr[3:0]", 128'(mem_addr[3:0]), 128'(0));  // whole lines only
            end
            if (mem_write_en && mem_ready) begin
                check("mem_wdata", mem_wdata, ref_line(mem_addr));
            end
        end
    end

    initial begin : stimulus
        logic [NP-1:0] active;
        logic [NP-1:0] expect_hit;
        int            next_op [NP];
        int            wait_cycles [NP];
        logic          busy_any;
        int            i;
        rst       = 1'b1;
        addr      = '0;
        read_en   = '0;
        write_en  = '0;
        byte_size = '0;
        wdata     = '0;
        active     = '0;
        expect_hit = '0;
        busy_any   = 1'b1;
        build_ops();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int l = 0; l < 512; l++) begin
            for (int b = 0; b < 16; b++) begin
                ref_mem[l*16 + b] = mem_model.line_mem[l][b*8 +: 8];
            end
        end
        repeat (3) begin  // quiet while nothing is requested
            @(negedge clk);
            check("ready", 128'(ready), 128'(0));
            check("mem_read_en", 128'(mem_read_en), 128'(0));
            check("mem_write_en", 128'(mem_write_en), 128'(0));
        end
        for (int p = 0; p < NP; p++) begin
            next_op[p]     = 0;
            wait_cycles[p] = 0;
        end
        while (busy_any) begin
            @(negedge clk);
            busy_any = 1'b0;
            for (int p = 0; p < NP; p++) begin
                if (active[p]) begin
                    wait_cycles[p]++;
                    if (ready[p]) begin
                        i = next_op[p] - 1;
                        if (op_write[p][i]) begin
                            apply_write(op_addr[p][i], op_size[p][i], op_wdata[p][i]);
                        end else begin
                            check($sformatf("rdata[%0d]", p), 128'(rdata[p]),
                                  128'(expected_read(op_addr[p][i], op_size[p][i])));
                        end
                        if (expect_hit[p]) begin
                            check($sformatf("hit latency of port %0d", p),
                                  128'(wait_cycles[p]), 128'(1));
                        end
                        active[p] = 1'b0;  // request held through the ready cycle
                    end
                end else begin
                    check($sformatf("ready[%0d]", p), 128'(ready[p]), 128'(0));
                    if (next_op[p] < op_count[p]) begin
                        i = next_op[p];
                        addr[p]        = op_addr[p][i];
                        byte_size[p]   = op_size[p][i];
                        wdata[p]       = op_wdata[p][i];
                        read_en[p]     = !op_write[p][i];
                        write_en[p]    = op_write[p][i];
                        expect_hit[p]  = (i > 0) &&
                                         (op_addr[p][i][31:4] == op_addr[p][i-1][31:4]);
                        wait_cycles[p] = 0;
                        active[p]      = 1'b1;
                        next_op[p]++;
                    end else begin
                        read_en[p]  = 1'b0;
                        write_en[p] = 1'b0;
                    end
                end
                if (active[p] || next_op[p] < op_count[p]) begin
                    busy_any = 1'b1;
                end
            end
        end
        @(negedge clk);
        read_en  = '0;
        write_en = '0;
        repeat (4) @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

//--- mem_controller.f
verilog/mem_ctrl_pkg.sv
verilog/line_cache.sv
verilog/cache_port.sv
verilog/offchip_arbiter.sv
verilog/mem_controller.sv
dv/offchip_mem_model.sv
dv/mem_controller_tb.sv

//--- Makefile
TOP = mem_controller_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f mem_controller.f
	verilator --lint-only --top-module mem_controller verilog/mem_ctrl_pkg.sv \
		verilog/line_cache.sv verilog/cache_port.sv verilog/offchip_arbiter.sv \
		verilog/mem_controller.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f mem_controller.f
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "Verification passed" sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
